// File: include/i2c_init_table.svh
`ifndef I2C_INIT_TABLE_SVH
`define I2C_INIT_TABLE_SVH

// issue order, entry 0 first
// select switch channel 8, then set eeprom address and read one byte, ten times
localparam i2c_cmd_u INIT_CMDS [INIT_LENGTH] = '{
	{1'h1, 4'h2, 32'he808_0000}, // switch to eeprom channel
	{1'h0, 4'h2, 32'ha800_0000}, // eeprom addr 0
	{1'h1, 4'h2, 32'ha900_0000}, // read byte
	{1'h0, 4'h2, 32'ha801_0000},
	{1'h1, 4'h2, 32'ha900_0000},
	{1'h0, 4'h2, 32'ha802_0000},
	{1'h1, 4'h2, 32'ha900_0000},
	{1'h0, 4'h2, 32'ha803_0000},
	{1'h1, 4'h2, 32'ha900_0000},
	{1'h0, 4'h2, 32'ha804_0000},
	{1'h1, 4'h2, 32'ha900_0000},
	{1'h0, 4'h2, 32'ha805_0000}, // last mac byte next
	{1'h1, 4'h2, 32'ha900_0000},
	{1'h0, 4'h2, 32'ha806_0000}, // ip bytes from here
	{1'h1, 4'h2, 32'ha900_0000},
	{1'h0, 4'h2, 32'ha807_0000},
	{1'h1, 4'h2, 32'ha900_0000},
	{1'h0, 4'h2, 32'ha808_0000},
	{1'h1, 4'h2, 32'ha900_0000},
	{1'h0, 4'h2, 32'ha809_0000},
	{1'h1, 4'h2, 32'ha900_0000}  // tenth byte
};

`endif

// File: rtl/board_pkg.sv
`default_nettype none

package board_pkg;

	// bring-up steps, walked in index order
	localparam int NUM_STEPS = 4;

	typedef enum logic [1:0] {
		STEP_CLK        = 2'd0, // external clock lock
		STEP_I2C_ENGINE = 2'd1, // i2c bit engine reset
		STEP_I2C_INIT   = 2'd2, // init table run
		STEP_ID_LOAD    = 2'd3  // mac/ip load strobe
	} step_e;

	// network identity as the ethernet side wants it
	typedef struct packed {
		logic [47:0] mac;
		logic [31:0] ip;
	} net_identity_t;

	// board default when the eeprom is not trusted
	localparam logic [47:0] DEFAULT_MAC = 48'h503e_aa05_9701;
	localparam logic [31:0] DEFAULT_IP  = 32'hc0a8_01e0; // 192.168.1.224

endpackage

`default_nettype wire

// File: rtl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	// plain view of a command word as the engine takes it
	typedef struct packed {
		logic        stop;
		logic [3:0]  nack; // nack retries allowed
		logic [31:0] data;
	} i2c_field_t;

	// same word seen as an addressed transfer
	typedef struct packed {
		logic        stop;
		logic [3:0]  nack;
		logic [7:0]  dev;  // device byte, bit 0 set for read
		logic [7:0]  loc;  // mux channel or register address
		logic [15:0] pad;
	} i2c_addr_t;

	typedef union packed {
		i2c_field_t field;
		i2c_addr_t  addr;
	} i2c_cmd_u;

	typedef struct packed {
		logic     start; // one-cycle strobe
		i2c_cmd_u cmd;
	} i2c_req_t;

	typedef struct packed {
		logic        valid; // one-cycle strobe from the engine
		logic [31:0] data;
	} i2c_res_t;

	localparam int          INIT_LENGTH     = 21;
	localparam logic [7:0]  MUX_DEV_ADDR    = 8'he8; // i2c switch, write address
	localparam logic [7:0]  EEPROM_LOCATION = 8'd8;  // switch channel of the id eeprom
	localparam int          ID_BYTES        = 10;    // 6 mac + 4 ip

	`include "i2c_init_table.svh"

endpackage

`default_nettype wire

// File: rtl/reset_chain.sv
`timescale 1ns/1ps
`default_nettype none

module reset_chain #(
	parameter int NUM_STEPS = 4,
	parameter int RESET_LEN = 4
) (
	input  logic                 hw,
	input  logic                 poweronreset,
	input  logic                 hwreset_req,   // host restart strobe
	input  logic [NUM_STEPS-1:0] done_criteria,
	output logic [NUM_STEPS-1:0] step_reset,
	output logic [NUM_STEPS-1:0] step_done
);

	localparam int IDX_W = (NUM_STEPS > 1) ? $clog2(NUM_STEPS) : 1;
	localparam int CNT_W = (RESET_LEN > 1) ? $clog2(RESET_LEN) : 1;

	logic [IDX_W-1:0] cur;           // step being brought up
	logic [CNT_W-1:0] cnt;           // reset pulse length
	logic             waiting;       // pulse over, waiting on done
	logic             running;
	logic             start_pending; // first cycle out of power-on
	logic             last_step;
	logic             pulse_end;

	assign last_step = (cur == IDX_W'(NUM_STEPS - 1));
	assign pulse_end = (cnt == CNT_W'(RESET_LEN - 1));

	// one step in reset at a time
	assign step_reset = (running && !waiting) ? (NUM_STEPS'(1) << cur) : '0;

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			start_pending <= 1'b1;
			running       <= 1'b0;
			waiting       <= 1'b0;
			cur           <= '0;
			cnt           <= '0;
			step_done     <= '0;
		end else if (start_pending || hwreset_req) begin
			// (re)start from step 0
			start_pending <= 1'b0;
			running       <= 1'b1;
			waiting       <= 1'b0;
			cur           <= '0;
			cnt           <= '0;
			step_done     <= '0;
		end else if (running) begin
			if (!waiting) begin
				if (pulse_end) begin
					waiting <= 1'b1;
					cnt     <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else if (step_done[cur]) begin
				// done recorded last cycle, move on
				if (last_step) begin
					running <= 1'b0; // whole chain up
				end else begin
					cur     <= cur + 1'b1;
					waiting <= 1'b0;
				end
			end else if (done_criteria[cur]) begin
				step_done[cur] <= 1'b1;
			end
		end
	end

	// never two steps in reset together
	assert property (@(posedge hw) disable iff (poweronreset)
		$onehot0(step_reset))
		else $error("reset_chain: more than one step in reset");

	// a later step only starts once the one before it is done
	for (genvar k = 1; k < NUM_STEPS; k++) begin : g_order
		assert property (@(posedge hw) disable iff (poweronreset)
			$rose(step_reset[k]) |-> step_done[k-1])
			else $error("reset_chain: step %0d started early", k);
	end

endmodule

`default_nettype wire

// File: rtl/i2c_init_seq.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_init_seq
	import i2c_pkg::*;
(
	input  logic     hw,
	input  logic     poweronreset,
	input  logic     seq_reset,  // step reset from the chain
	input  i2c_cmd_u live_cmd,
	input  logic     live_start, // host strobe honoured after init
	input  i2c_res_t i2c_res,
	output i2c_req_t i2c_req,
	output logic     init_done,
	output i2c_res_t result      // last answer from the engine
);

	localparam int IDX_W = $clog2(INIT_LENGTH);

	logic [IDX_W-1:0] idx;      // table entry in flight
	logic [IDX_W-1:0] idx_next;
	logic             busy;     // start sent and result pending
	logic             last_entry;

	assign idx_next   = idx + 1'b1;
	assign last_entry = (idx == IDX_W'(INIT_LENGTH - 1));

	always_ff @(posedge hw) begin
		if (poweronreset || seq_reset) begin
			idx           <= '0;
			busy          <= 1'b0;
			init_done     <= 1'b0;
			i2c_req.start <= 1'b0;
			i2c_req.cmd   <= '0;
			result        <= '0;
		end else begin
			i2c_req.start <= 1'b0; // strobe for one cycle only
			if (busy) begin
				if (i2c_res.valid) begin
					busy   <= 1'b0;
					result <= i2c_res;
					if (!init_done) begin
						if (last_entry) begin
							init_done <= 1'b1; // table finished
						end else begin
							// chain straight into the next entry
							idx           <= idx_next;
							i2c_req.start <= 1'b1;
							i2c_req.cmd   <= INIT_CMDS[idx_next];
							busy          <= 1'b1;
						end
					end
				end
			end else if (!init_done) begin
				// first entry after reset drops
				i2c_req.start <= 1'b1;
				i2c_req.cmd   <= INIT_CMDS[idx];
				busy          <= 1'b1;
			end else if (live_start) begin
				i2c_req.start <= 1'b1; // host pass-through
				i2c_req.cmd   <= live_cmd;
				busy          <= 1'b1;
			end
		end
	end

	// engine has to answer before another command goes out
	assert property (@(posedge hw) disable iff (poweronreset || seq_reset)
		busy && !i2c_res.valid |=> !i2c_req.start)
		else $error("i2c_init_seq: start while a command is outstanding");

endmodule

`default_nettype wire

// File: rtl/net_identity.sv
`timescale 1ns/1ps
`default_nettype none

module net_identity
	import board_pkg::*, i2c_pkg::*;
(
	input  logic          hw,
	input  logic          poweronreset,
	input  i2c_req_t      i2c_req,
	input  i2c_res_t      i2c_res,
	input  logic          init_done,
	input  logic          load,        // load step reset from the chain
	input  logic          use_default, // board switch
	output net_identity_t identity
);

	i2c_cmd_u              cur_cmd;  // command the engine is answering
	logic [7:0]            mux_loc;  // switch channel last selected
	logic [ID_BYTES*8-1:0] record;   // eeprom bytes with the first read in the msb
	logic                  sel_mux;
	logic                  take_byte;

	// switch address byte has the write flag clear
	assign sel_mux = i2c_req.start && (i2c_req.cmd.addr.dev == MUX_DEV_ADDR);

	// read answers from the id eeprom during the init run only
	assign take_byte = i2c_res.valid && !init_done
		&& (mux_loc == EEPROM_LOCATION)
		&& cur_cmd.addr.dev[0];

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			mux_loc <= '0;
		end else if (sel_mux) begin
			mux_loc <= i2c_req.cmd.addr.loc;
		end
	end

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			cur_cmd <= '0;
			record  <= '0;
		end else begin
			if (i2c_req.start) begin
				cur_cmd <= i2c_req.cmd; // held until the next start
			end
			if (take_byte) begin
				record <= {record[ID_BYTES*8-9:0], i2c_res.data[7:0]};
			end
		end
	end

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			identity <= '0;
		end else if (load) begin
			identity <= use_default ? net_identity_t'{mac: DEFAULT_MAC, ip: DEFAULT_IP}
				: net_identity_t'(record);
		end
	end

	// record frozen for as long as init stays done
	assert property (@(posedge hw) disable iff (poweronreset)
		init_done && $past(init_done) |-> $stable(record))
		else $error("net_identity: eeprom record changed after init");

endmodule

`default_nettype wire

// File: rtl/board_init.sv
`timescale 1ns/1ps
`default_nettype none

module board_init
	import board_pkg::*, i2c_pkg::*;
#(
	parameter int RESET_LEN = 4
) (
	input  logic                 hw,
	input  logic                 poweronreset,
	input  logic                 hwreset_req,
	input  logic [1:0]           ext_done,  // clock lock, engine reset done
	input  i2c_res_t             i2c_res,
	input  i2c_cmd_u             live_cmd,
	input  logic                 live_start,
	input  logic                 use_default,
	output logic [1:0]           ext_reset, // clock block, i2c engine
	output logic [NUM_STEPS-1:0] step_done,
	output i2c_req_t             i2c_req,
	output logic                 init_done,
	output i2c_res_t             result,
	output net_identity_t        identity
);

	logic [NUM_STEPS-1:0] step_reset;
	logic [NUM_STEPS-1:0] done_criteria;

	// external steps
	assign ext_reset[0] = step_reset[STEP_CLK];
	assign ext_reset[1] = step_reset[STEP_I2C_ENGINE];

	assign done_criteria[STEP_CLK]        = ext_done[0];
	assign done_criteria[STEP_I2C_ENGINE] = ext_done[1];
	assign done_criteria[STEP_I2C_INIT]   = init_done;
	assign done_criteria[STEP_ID_LOAD]    = ~step_reset[STEP_ID_LOAD]; // done once strobe drops

	reset_chain #(
		.NUM_STEPS (NUM_STEPS),
		.RESET_LEN (RESET_LEN)
	) i_reset_chain (
		.hw            (hw),
		.poweronreset  (poweronreset),
		.hwreset_req   (hwreset_req),
		.done_criteria (done_criteria),
		.step_reset    (step_reset),
		.step_done     (step_done)
	);

	i2c_init_seq i_i2c_init_seq (
		.hw           (hw),
		.poweronreset (poweronreset),
		.seq_reset    (step_reset[STEP_I2C_INIT]),
		.live_cmd     (live_cmd),
		.live_start   (live_start),
		.i2c_res      (i2c_res),
		.i2c_req      (i2c_req),
		.init_done    (init_done),
		.result       (result)
	);

	net_identity i_net_identity (
		.hw           (hw),
		.poweronreset (poweronreset),
		.i2c_req      (i2c_req),
		.i2c_res      (i2c_res),
		.init_done    (init_done),
		.load         (step_reset[STEP_ID_LOAD]),
		.use_default  (use_default),
		.identity     (identity)
	);

	// identity only loads from a finished eeprom read
	assert property (@(posedge hw) disable iff (poweronreset)
		step_reset[STEP_ID_LOAD] |-> init_done)
		else $error("board_init: identity load before i2c init done");

endmodule

`default_nettype wire

// File: verif/board_init_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_init_tb
	import board_pkg::*, i2c_pkg::*;
();

	localparam int RESET_LEN       = 4;
	localparam int WATCHDOG_CYCLES = 40 * 2 * (INIT_LENGTH + 1 + NUM_STEPS); // both runs

	// golden word layout
	localparam int G_CMD       = 10; // eeprom bytes sit below
	localparam int G_LIVE_CMD  = 31;
	localparam int G_LIVE_DATA = 32;
	localparam int G_RUN1_SEL  = 33;
	localparam int G_RUN1_ID   = 34;
	localparam int G_RUN2_SEL  = 35;
	localparam int G_RUN2_ID   = 36;

	logic [79:0] golden [0:36];

	logic                 hw           = 1'b0;
	logic                 poweronreset = 1'b1;
	logic                 hwreset_req  = 1'b0;
	logic [1:0]           ext_done     = 2'b00;
	i2c_res_t             i2c_res      = '0;
	i2c_cmd_u             live_cmd     = '0;
	logic                 live_start   = 1'b0;
	logic                 use_default  = 1'b0;
	logic [1:0]           ext_reset;
	logic [NUM_STEPS-1:0] step_done;
	i2c_req_t             i2c_req;
	logic                 init_done;
	i2c_res_t             result;
	net_identity_t        identity;

	integer      seed          = 32'h35bc_984f;
	logic        eng_busy      = 1'b0; // engine holds a command
	int          eng_wait      = 0;
	logic [31:0] eng_answer    = '0;
	logic [7:0]  model_loc     = '0;   // switch channel seen by the engine
	int          model_ptr     = 0;    // eeprom address pointer
	logic [1:0]  done_armed    = 2'b00;
	int          done_wait [2] = '{0, 0};

	int          pulse_len [2] = '{0, 0};
	logic [1:0]  prev_reset    = 2'b00;
	logic        prev_valid    = 1'b0;
	logic        prev_init     = 1'b0;
	int          cmd_idx       = 0;
	int          res_count     = 0;
	int          table_runs    = 0;

	board_init #(
		.RESET_LEN (RESET_LEN)
	) i_dut (
		.hw           (hw),
		.poweronreset (poweronreset),
		.hwreset_req  (hwreset_req),
		.ext_done     (ext_done),
		.i2c_res      (i2c_res),
		.live_cmd     (live_cmd),
		.live_start   (live_start),
		.use_default  (use_default),
		.ext_reset    (ext_reset),
		.step_done    (step_done),
		.i2c_req      (i2c_req),
		.init_done    (init_done),
		.result       (result),
		.identity     (identity)
	);

	initial begin
		forever #50 hw = ~hw; // 100 ns
	end

	task automatic stop_on_mismatch(input string what);
		$display("mismatch at %0t ns: %s", $time, what);
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	// eeprom behind switch channel 8, everything else answers zero
	function automatic logic [31:0] engine_answer(input logic [31:0] data);
		logic [7:0] dev;
		logic [7:0] loc;
		dev = data[31:24];
		loc = data[23:16];
		engine_answer = '0;
		if (dev == MUX_DEV_ADDR) begin
			model_loc = loc;
		end else if (model_loc == EEPROM_LOCATION) begin
			if (dev[0]) begin
				if (model_ptr < ID_BYTES) begin
					engine_answer = {24'h0, golden[model_ptr][7:0]};
				end
				model_ptr = model_ptr + 1; // sequential read
			end else begin
				model_ptr = int'(loc);
			end
		end
	endfunction

	// i2c engine and the two external done lines
	always @(posedge hw) begin
		i2c_res <= '0;
		if (poweronreset || ext_reset[1]) begin
			eng_busy = 1'b0; // engine held in reset drops its command
		end else if (eng_busy) begin
			if (eng_wait == 0) begin
				i2c_res  <= {1'b1, eng_answer};
				eng_busy = 1'b0;
			end else begin
				eng_wait = eng_wait - 1;
			end
		end else if (i2c_req.start && ext_done[1]) begin
			eng_answer = engine_answer(i2c_req.cmd.field.data);
			eng_wait   = $unsigned($random(seed)) % 6; // 1 to 6 cycles
			eng_busy   = 1'b1;
		end
		for (int k = 0; k < 2; k++) begin
			if (poweronreset || ext_reset[k]) begin
				ext_done[k] <= 1'b0;
				done_armed[k] = ext_reset[k];
				done_wait[k]  = $unsigned($random(seed)) % 8;
			end else if (done_armed[k] && !ext_done[k]) begin
				if (done_wait[k] == 0) begin
					ext_done[k] <= 1'b1;
				end else begin
					done_wait[k] = done_wait[k] - 1;
				end
			end
		end
	end

	// mid-cycle checks on pulses, step order and the command stream
	always @(negedge hw) begin
		if (!poweronreset) begin
			if (hwreset_req) begin
				cmd_idx   = 0;
				res_count = 0;
			end
			assert (!(ext_reset[0] && ext_reset[1]))
				else stop_on_mismatch("both ext_reset bits high");
			for (int k = 0; k < 2; k++) begin
				if (ext_reset[k]) begin
					pulse_len[k] = pulse_len[k] + 1;
				end else if (prev_reset[k]) begin
					assert (pulse_len[k] == RESET_LEN)
						else stop_on_mismatch($sformatf("ext_reset[%0d] high %0d cycles",
							k, pulse_len[k]));
					pulse_len[k] = 0;
				end
			end
			if (ext_reset[1] && !prev_reset[1]) begin
				assert (ext_done[0] && step_done[0])
					else stop_on_mismatch("ext_reset[1] rose before step 0 was done");
			end
			if (i2c_req.start && ext_done[1] && !init_done) begin
				assert (cmd_idx < INIT_LENGTH && i2c_req.cmd == golden[G_CMD + cmd_idx][36:0])
					else stop_on_mismatch($sformatf("init command %0d is %h", cmd_idx,
						i2c_req.cmd));
				cmd_idx = cmd_idx + 1;
			end
			if (i2c_res.valid && !init_done) begin
				res_count = res_count + 1;
			end
			if (init_done && !prev_init) begin
				assert (cmd_idx == INIT_LENGTH && res_count == INIT_LENGTH && prev_valid)
					else stop_on_mismatch("init_done not one cycle after the last result");
				table_runs = table_runs + 1;
			end
			prev_reset = ext_reset;
			prev_valid = i2c_res.valid;
			prev_init  = init_done;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge hw);
		$display("timeout: bring-up did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

	task automatic finish_bringup(input int id_word);
		while (step_done != '1) @(negedge hw);
		assert (identity == golden[id_word])
			else stop_on_mismatch($sformatf("identity %h, expected %h", identity,
				golden[id_word]));
	endtask

	task automatic issue_live_cmd();
		@(posedge hw);
		live_start <= 1'b1;
		@(posedge hw);
		live_start <= 1'b0;
		@(negedge hw);
		assert (i2c_req.start && i2c_req.cmd == golden[G_LIVE_CMD][36:0])
			else stop_on_mismatch("live command not forwarded a cycle later");
		while (!i2c_res.valid) @(negedge hw);
		@(negedge hw);
		assert (result == {1'b1, golden[G_LIVE_DATA][31:0]})
			else stop_on_mismatch($sformatf("live result %h", result));
	endtask

	initial begin
		$readmemh("verif/board_init_golden.txt", golden);
		@(posedge hw);
		live_cmd    <= golden[G_LIVE_CMD][36:0];
		use_default <= golden[G_RUN1_SEL][0];
		@(negedge hw);
		assert (ext_reset == 2'b00 && step_done == '0 && !i2c_req.start && !init_done)
			else stop_on_mismatch("outputs not cleared in poweronreset");
		@(posedge hw);
		poweronreset <= 1'b0; // two reset cycles
		finish_bringup(G_RUN1_ID);
		issue_live_cmd();
		@(posedge hw);
		hwreset_req <= 1'b1;
		use_default <= golden[G_RUN2_SEL][0];
		@(posedge hw);
		hwreset_req <= 1'b0;
		@(negedge hw);
		assert (step_done == '0) else stop_on_mismatch("step_done kept after restart");
		finish_bringup(G_RUN2_ID);
		if (table_runs == 2) begin
			$display("** PASS **");
			$finish;
		end else begin
			stop_on_mismatch($sformatf("init table ran %0d times", table_runs));
		end
	end

endmodule

`default_nettype wire

// File: verif/board_init_golden.txt
// one hex word per line: [0:9] eeprom bytes, [10:30] init commands {stop, nack, data}
// [31] live command, [32] its answer, [33]/[35] use_default per run, [34]/[36] {mac, ip}
02
1a
3c
5e
7f
91
c0
a8
0a
2a
12e8080000 // switch to channel 8
02a8000000
12a9000000
02a8010000
12a9000000
02a8020000
12a9000000
02a8030000
12a9000000
02a8040000
12a9000000
02a8050000
12a9000000
02a8060000
12a9000000
02a8070000
12a9000000
02a8080000
12a9000000
02a8090000
12a9000000
12e8030000 // live: switch to channel 3
00000000
0
021a3c5e7f91c0a80a2a // eeprom identity
1
503eaa059701c0a801e0 // board default

// File: board_init.f
+incdir+include
rtl/board_pkg.sv
rtl/i2c_pkg.sv
rtl/reset_chain.sv
rtl/i2c_init_seq.sv
rtl/net_identity.sv
rtl/board_init.sv
verif/board_init_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = board_init_tb
FILELIST = board_init.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
